//--- drone_ctrl.f
logic/drone_pkg.sv
logic/timebase.sv
logic/rc_pulse_decoder.sv
logic/arming_controller.sv
logic/attitude_controller.sv
logic/rate_controller.sv
logic/motor_mixer.sv
logic/esc_pwm_generator.sv
logic/drone_ctrl.sv
test/drone_ctrl_tb.sv

//--- Bender.yml
package:
  name: drone_ctrl

sources:
  - logic/drone_pkg.sv
  - logic/timebase.sv
  - logic/rc_pulse_decoder.sv
  - logic/arming_controller.sv
  - logic/attitude_controller.sv
  - logic/rate_controller.sv
  - logic/motor_mixer.sv
  - logic/esc_pwm_generator.sv
  - logic/drone_ctrl.sv
  - target: test
    files:
      - test/drone_ctrl_tb.sv

//--- test/drone_ctrl_tb.sv
module drone_ctrl_tb import drone_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int FRAME_CYC   = FRAME_US * TICKS_PER_US;

    // Receiver frame is shorter than the ESC frame
    localparam int RC_FRAME_CYC  = 3000 * TICKS_PER_US;
    // Point in the receiver frame where every pulse has ended and decoded
    localparam int RC_SETTLE_CYC = 2400 * TICKS_PER_US;

    // Whole sequence takes about seven ESC frames
    localparam int TIMEOUT_CYC = 12 * FRAME_CYC + 2 * RC_FRAME_CYC;

    // Receiver channel slots
    localparam int CH_THR   = 0;
    localparam int CH_YAW   = 1;
    localparam int CH_ROLL  = 2;
    localparam int CH_PITCH = 3;
    localparam int CH_MODE  = 4;

    // One mode switch position per band
    localparam int MODE_OFF_POS  = 40;
    localparam int MODE_STAB_POS = 125;
    localparam int MODE_ACRO_POS = 210;

    logic  sys_clk;
    logic  resetn;
    logic  throttle_pwm;
    logic  yaw_pwm;
    logic  roll_pwm;
    logic  pitch_pwm;
    logic  swa_swb_pwm;
    logic  imu_valid;
    rate_t roll_angle;
    rate_t pitch_angle;
    rate_t roll_rate;
    rate_t pitch_rate;
    rate_t yaw_rate;
    logic  motor_1_pwm;
    logic  motor_2_pwm;
    logic  motor_3_pwm;
    logic  motor_4_pwm;
    logic  armed;

    // Requested and active receiver widths in us
    int rc_us [5];
    int rc_active [5];
    int rc_cnt = 0;

    // IMU sample as sent with the strobe
    int sent_roll_angle = 0;
    int sent_pitch_angle = 0;
    int sent_roll_rate = 0;
    int sent_pitch_rate = 0;
    int sent_yaw_rate = 0;

    // ESC pulse monitor
    logic [3:0] pwm_now;
    logic [3:0] pwm_prev = '0;
    logic [3:0] fell = '0;
    int         high_cyc [4];
    int         width_cyc [4];
    int         frame_cnt = 0;

    int          exp_width [4];
    int          cycle_cnt = 0;
    logic [31:0] lfsr_state = 32'hbc98;

    drone_ctrl drone_ctrl_i (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .throttle_pwm(throttle_pwm),
        .yaw_pwm     (yaw_pwm),
        .roll_pwm    (roll_pwm),
        .pitch_pwm   (pitch_pwm),
        .swa_swb_pwm (swa_swb_pwm),
        .imu_valid   (imu_valid),
        .roll_angle  (roll_angle),
        .pitch_angle (pitch_angle),
        .roll_rate   (roll_rate),
        .pitch_rate  (pitch_rate),
        .yaw_rate    (yaw_rate),
        .motor_1_pwm (motor_1_pwm),
        .motor_2_pwm (motor_2_pwm),
        .motor_3_pwm (motor_3_pwm),
        .motor_4_pwm (motor_4_pwm),
        .armed       (armed)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    task automatic stop_failed(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            stop_failed($sformatf("** Error: %s expected 0x%0h, actual 0x%0h",
                                  name, expected, actual));
        end
    endtask

    // Galois LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic random_stick(output int v);
        random_bits(8, v);
        v = v % (STICK_MAX + 1);
    endtask

    task automatic random_signed(input int n, output int v);
        random_bits(n, v);
        v = v - (1 << (n - 1));
    endtask

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v < lo) begin
            return lo;
        end else if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    // Mid-step width, so a count one us short still decodes the same
    function automatic int pulse_for(input int v);
        return PULSE_MIN_US + US_PER_STEP * v + 2;
    endfunction

    // Receiver width to stick value
    function automatic int stick_of(input int w_us);
        return (clamp(w_us, PULSE_MIN_US, PULSE_MAX_US) - PULSE_MIN_US) / US_PER_STEP;
    endfunction

    // P term as a floor shift and then a limit
    function automatic int corr_of(input int target, input int rate);
        return clamp((target - rate) >>> RATE_SHIFT, -CORR_LIMIT, CORR_LIMIT);
    endfunction

    task automatic expect_idle();
        for (int i = 0; i < 4; i++) begin
            exp_width[i] = PULSE_MIN_US;
        end
    endtask

    // Reference for the whole chain from requested widths and the sent IMU sample
    task automatic expect_widths(input bit acro);
        int thr;
        int roll_t;
        int pitch_t;
        int yaw_t;
        int rc;
        int pc;
        int yc;
        int mix [4];
        thr     = stick_of(rc_us[CH_THR]);
        roll_t  = stick_of(rc_us[CH_ROLL]) - STICK_CENTER;
        pitch_t = stick_of(rc_us[CH_PITCH]) - STICK_CENTER;
        yaw_t   = stick_of(rc_us[CH_YAW]) - STICK_CENTER;
        // Angles only count in stabilize
        if (!acro) begin
            roll_t  = roll_t - sent_roll_angle;
            pitch_t = pitch_t - sent_pitch_angle;
        end
        rc = corr_of(roll_t, sent_roll_rate);
        pc = corr_of(pitch_t, sent_pitch_rate);
        yc = corr_of(yaw_t, sent_yaw_rate);
        // Quad-X order is FL, FR, RR, RL
        mix[0] = thr + pc + rc - yc;
        mix[1] = thr + pc - rc + yc;
        mix[2] = thr - pc - rc - yc;
        mix[3] = thr - pc + rc + yc;
        for (int i = 0; i < 4; i++) begin
            exp_width[i] = PULSE_MIN_US + US_PER_STEP * clamp(mix[i], 0, STICK_MAX);
        end
    endtask

    // All channels rise at frame start and each falls after its active width
    always @(posedge sys_clk) begin
        if (rc_cnt == 0) begin
            for (int ch = 0; ch < 5; ch++) begin
                rc_active[ch] = rc_us[ch];
            end
        end
        #(DRIVE_DELAY);
        throttle_pwm = (rc_cnt < rc_active[CH_THR] * TICKS_PER_US);
        yaw_pwm      = (rc_cnt < rc_active[CH_YAW] * TICKS_PER_US);
        roll_pwm     = (rc_cnt < rc_active[CH_ROLL] * TICKS_PER_US);
        pitch_pwm    = (rc_cnt < rc_active[CH_PITCH] * TICKS_PER_US);
        swa_swb_pwm  = (rc_cnt < rc_active[CH_MODE] * TICKS_PER_US);
        rc_cnt = (rc_cnt == RC_FRAME_CYC - 1) ? 0 : rc_cnt + 1;
    end

    // Wait for a full receiver frame carrying the requested widths
    task automatic wait_rc_update();
        @(posedge sys_clk);
        while (rc_cnt != 0) begin
            @(posedge sys_clk);
        end
        while (rc_cnt != RC_SETTLE_CYC) begin
            @(posedge sys_clk);
        end
        #(DRIVE_DELAY);
    endtask

    // Motor 1 rising marks a new ESC frame
    assign pwm_now = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

    always @(posedge sys_clk) begin
        pwm_prev <= pwm_now;
        if (pwm_now[0] && !pwm_prev[0]) begin
            frame_cnt <= frame_cnt + 1;
            fell      <= 4'b0000;
        end
        for (int i = 0; i < 4; i++) begin
            if (pwm_now[i]) begin
                high_cyc[i] <= pwm_prev[i] ? high_cyc[i] + 1 : 1;
            end else if (pwm_prev[i]) begin
                width_cyc[i] <= high_cyc[i];
                fell[i]      <= 1'b1;
            end
        end
    end

    // Measure the next full ESC frame with armed held at its expected level
    task automatic measure_frame(input logic exp_armed);
        int start_frame;
        start_frame = frame_cnt;
        @(posedge sys_clk);
        while (frame_cnt == start_frame || fell != 4'b1111) begin
            check_value("armed", exp_armed, armed);
            @(posedge sys_clk);
        end
        for (int i = 0; i < 4; i++) begin
            assert (width_cyc[i] % TICKS_PER_US == 0) else begin
                stop_failed($sformatf("motor_%0d_pwm pulse is not a whole number of us",
                                      i + 1));
            end
            check_value($sformatf("motor_%0d_pwm width", i + 1), exp_width[i],
                        width_cyc[i] / TICKS_PER_US);
        end
        #(DRIVE_DELAY);
    endtask

    // Sample valid for one cycle only
    task automatic apply_imu(input int ra, input int pa, input int rr, input int pr,
                             input int yr);
        sent_roll_angle  = ra;
        sent_pitch_angle = pa;
        sent_roll_rate   = rr;
        sent_pitch_rate  = pr;
        sent_yaw_rate    = yr;
        roll_angle  = rate_t'(ra);
        pitch_angle = rate_t'(pa);
        roll_rate   = rate_t'(rr);
        pitch_rate  = rate_t'(pr);
        yaw_rate    = rate_t'(yr);
        imu_valid   = 1'b1;
        @(posedge sys_clk);
        #(DRIVE_DELAY);
        imu_valid = 1'b0;
        // Unrelated data on the pins once the strobe is gone
        roll_angle  = ~rate_t'(ra);
        pitch_angle = ~rate_t'(pa);
        roll_rate   = ~rate_t'(rr);
        pitch_rate  = ~rate_t'(pr);
        yaw_rate    = ~rate_t'(yr);
        // Past the three stages and any frame they overlapped
        repeat (6) @(posedge sys_clk);
        #(DRIVE_DELAY);
    endtask

    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYC) begin
            stop_failed($sformatf("Timeout, sequence still running after %0d cycles",
                                  cycle_cnt));
        end
    end

    initial begin
        int v;
        int ra;
        int pa;
        int rr;
        int pr;
        int yr;
        resetn       = 1'b0;
        throttle_pwm = 1'b0;
        yaw_pwm      = 1'b0;
        roll_pwm     = 1'b0;
        pitch_pwm    = 1'b0;
        swa_swb_pwm  = 1'b0;
        imu_valid    = 1'b0;
        roll_angle   = '0;
        pitch_angle  = '0;
        roll_rate    = '0;
        pitch_rate   = '0;
        yaw_rate     = '0;
        for (int i = 0; i < 4; i++) begin
            high_cyc[i]  = 0;
            width_cyc[i] = 0;
        end
        // Throttle starts high so the first arm attempt is refused
        rc_us[CH_THR]   = pulse_for(200);
        rc_us[CH_YAW]   = pulse_for(STICK_CENTER);
        rc_us[CH_ROLL]  = pulse_for(STICK_CENTER);
        rc_us[CH_PITCH] = pulse_for(STICK_CENTER);
        rc_us[CH_MODE]  = pulse_for(MODE_OFF_POS);
        repeat (2) @(posedge sys_clk);
        #(DRIVE_DELAY);
        resetn = 1'b1;

        // First frame idle and disarmed
        expect_idle();
        measure_frame(1'b0);

        // Switching on with high throttle is refused
        rc_us[CH_MODE] = pulse_for(MODE_STAB_POS);
        wait_rc_update();
        check_value("armed", 0, armed);
        // Lowering throttle alone does not arm
        rc_us[CH_THR] = pulse_for(0);
        wait_rc_update();
        check_value("armed", 0, armed);
        rc_us[CH_MODE] = pulse_for(MODE_OFF_POS);
        wait_rc_update();
        check_value("armed", 0, armed);
        // Passing through off with low throttle arms
        rc_us[CH_MODE] = pulse_for(MODE_STAB_POS);
        wait_rc_update();
        check_value("armed", 1, armed);

        // Stabilize with random sticks and IMU sample
        random_stick(v);
        rc_us[CH_THR] = pulse_for(v);
        random_stick(v);
        rc_us[CH_YAW] = pulse_for(v);
        random_stick(v);
        rc_us[CH_ROLL] = pulse_for(v);
        random_stick(v);
        rc_us[CH_PITCH] = pulse_for(v);
        wait_rc_update();
        check_value("armed", 1, armed);
        random_signed(8, ra);
        random_signed(8, pa);
        random_signed(9, rr);
        random_signed(9, pr);
        random_signed(9, yr);
        apply_imu(ra, pa, rr, pr, yr);
        expect_widths(1'b0);
        measure_frame(1'b1);

        // Acro with the same sticks and rates and new nonzero angles
        rc_us[CH_MODE] = pulse_for(MODE_ACRO_POS);
        wait_rc_update();
        random_signed(8, ra);
        random_signed(8, pa);
        if (ra == 0) begin
            ra = 1;
        end
        if (pa == 0) begin
            pa = -1;
        end
        apply_imu(ra, pa, rr, pr, yr);
        expect_widths(1'b1);
        measure_frame(1'b1);

        // Out-of-range pulses and corrections driven past the limit
        rc_us[CH_THR]   = 800;
        rc_us[CH_ROLL]  = 800;
        rc_us[CH_PITCH] = 2300;
        rc_us[CH_YAW]   = 2300;
        wait_rc_update();
        apply_imu(0, 0, 200, -200, -200);
        expect_widths(1'b1);
        measure_frame(1'b1);

        // Disarm leaves the motors idle from the next frame on
        rc_us[CH_MODE] = pulse_for(MODE_OFF_POS);
        wait_rc_update();
        check_value("armed", 0, armed);
        expect_idle();
        measure_frame(1'b0);
        measure_frame(1'b0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- logic/drone_ctrl.sv
module drone_ctrl import drone_pkg::*; (
    input  logic  sys_clk,
    input  logic  resetn,
    // Receiver pulses
    input  logic  throttle_pwm,
    input  logic  yaw_pwm,
    input  logic  roll_pwm,
    input  logic  pitch_pwm,
    input  logic  swa_swb_pwm,
    // IMU sample, valid for one cycle
    input  logic  imu_valid,
    input  rate_t roll_angle,
    input  rate_t pitch_angle,
    input  rate_t roll_rate,
    input  rate_t pitch_rate,
    input  rate_t yaw_rate,
    // ESC outputs
    output logic  motor_1_pwm,
    output logic  motor_2_pwm,
    output logic  motor_3_pwm,
    output logic  motor_4_pwm,
    output logic  armed
);

    logic us_tick;
    logic frame_start;

    // Decoded sticks
    stick_t throttle_val;
    stick_t yaw_val;
    stick_t roll_val;
    stick_t pitch_val;
    stick_t swa_swb_val;

    flight_mode_t flight_mode;
    stick_t       throttle_cmd;

    // Control chain
    rate_t  roll_target;
    rate_t  pitch_target;
    rate_t  yaw_target;
    logic   targets_valid;
    rate_t  roll_corr;
    rate_t  pitch_corr;
    rate_t  yaw_corr;
    logic   corr_valid;
    stick_t motor_1_rate;
    stick_t motor_2_rate;
    stick_t motor_3_rate;
    stick_t motor_4_rate;

    timebase timebase_i (
        .sys_clk     (sys_clk),
        .resetn      (resetn),
        .us_tick     (us_tick),
        .frame_start (frame_start)
    );

    rc_pulse_decoder throttle_decoder_i (
        .sys_clk  (sys_clk),
        .resetn   (resetn),
        .us_tick  (us_tick),
        .pulse_in (throttle_pwm),
        .value    (throttle_val)
    );

    rc_pulse_decoder yaw_decoder_i (
        .sys_clk  (sys_clk),
        .resetn   (resetn),
        .us_tick  (us_tick),
        .pulse_in (yaw_pwm),
        .value    (yaw_val)
    );

    rc_pulse_decoder roll_decoder_i (
        .sys_clk  (sys_clk),
        .resetn   (resetn),
        .us_tick  (us_tick),
        .pulse_in (roll_pwm),
        .value    (roll_val)
    );

    rc_pulse_decoder pitch_decoder_i (
        .sys_clk  (sys_clk),
        .resetn   (resetn),
        .us_tick  (us_tick),
        .pulse_in (pitch_pwm),
        .value    (pitch_val)
    );

    // Mode switch channel
    rc_pulse_decoder mode_decoder_i (
        .sys_clk  (sys_clk),
        .resetn   (resetn),
        .us_tick  (us_tick),
        .pulse_in (swa_swb_pwm),
        .value    (swa_swb_val)
    );

    arming_controller arming_controller_i (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .mode_val     (swa_swb_val),
        .throttle_val (throttle_val),
        .flight_mode  (flight_mode),
        .armed        (armed),
        .throttle_cmd (throttle_cmd)
    );

    attitude_controller attitude_controller_i (
        .sys_clk       (sys_clk),
        .resetn        (resetn),
        .imu_valid     (imu_valid),
        .flight_mode   (flight_mode),
        .roll_stick    (roll_val),
        .pitch_stick   (pitch_val),
        .yaw_stick     (yaw_val),
        .roll_angle    (roll_angle),
        .pitch_angle   (pitch_angle),
        .roll_target   (roll_target),
        .pitch_target  (pitch_target),
        .yaw_target    (yaw_target),
        .targets_valid (targets_valid)
    );

    rate_controller rate_controller_i (
        .sys_clk       (sys_clk),
        .resetn        (resetn),
        .targets_valid (targets_valid),
        .roll_target   (roll_target),
        .pitch_target  (pitch_target),
        .yaw_target    (yaw_target),
        .roll_rate     (roll_rate),
        .pitch_rate    (pitch_rate),
        .yaw_rate      (yaw_rate),
        .roll_corr     (roll_corr),
        .pitch_corr    (pitch_corr),
        .yaw_corr      (yaw_corr),
        .corr_valid    (corr_valid)
    );

    motor_mixer motor_mixer_i (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .corr_valid   (corr_valid),
        .armed        (armed),
        .throttle_cmd (throttle_cmd),
        .roll_corr    (roll_corr),
        .pitch_corr   (pitch_corr),
        .yaw_corr     (yaw_corr),
        .motor_1_rate (motor_1_rate),
        .motor_2_rate (motor_2_rate),
        .motor_3_rate (motor_3_rate),
        .motor_4_rate (motor_4_rate)
    );

    esc_pwm_generator esc_pwm_generator_i (
        .sys_clk      (sys_clk),
        .resetn       (resetn),
        .us_tick      (us_tick),
        .frame_start  (frame_start),
        .motor_1_rate (motor_1_rate),
        .motor_2_rate (motor_2_rate),
        .motor_3_rate (motor_3_rate),
        .motor_4_rate (motor_4_rate),
        .motor_1_pwm  (motor_1_pwm),
        .motor_2_pwm  (motor_2_pwm),
        .motor_3_pwm  (motor_3_pwm),
        .motor_4_pwm  (motor_4_pwm)
    );

endmodule

//--- logic/esc_pwm_generator.sv
module esc_pwm_generator import drone_pkg::*; (
    input  logic   sys_clk,
    input  logic   resetn,
    input  logic   us_tick,
    input  logic   frame_start,
    input  stick_t motor_1_rate,
    input  stick_t motor_2_rate,
    input  stick_t motor_3_rate,
    input  stick_t motor_4_rate,
    output logic   motor_1_pwm,
    output logic   motor_2_pwm,
    output logic   motor_3_pwm,
    output logic   motor_4_pwm
);

    stick_t    rate_in [4];
    us_count_t width_q [4];
    logic [3:0] pwm_q;

    // Shared count of microseconds since frame start
    us_count_t us_cnt;
    us_count_t us_cnt_next;

    assign rate_in[0] = motor_1_rate;
    assign rate_in[1] = motor_2_rate;
    assign rate_in[2] = motor_3_rate;
    assign rate_in[3] = motor_4_rate;

    assign us_cnt_next = us_cnt + 1'b1;

    // Compare values fixed for the whole frame
    always_ff @(posedge sys_clk) begin
        if (frame_start) begin
            for (int i = 0; i < 4; i++) begin
                width_q[i] <= us_count_t'(PULSE_MIN_US) +
                              us_count_t'(US_PER_STEP) * us_count_t'(rate_in[i]);
            end
        end
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            us_cnt <= '0;
            pwm_q  <= '0;
        end else if (frame_start) begin
            // All outputs rise together
            us_cnt <= '0;
            pwm_q  <= '1;
        end else if (us_tick) begin
            us_cnt <= us_cnt_next;
            // Fall on the tick that completes the commanded width
            for (int i = 0; i < 4; i++) begin
                if (us_cnt_next == width_q[i]) begin
                    pwm_q[i] <= 1'b0;
                end
            end
        end
    end

    assign motor_1_pwm = pwm_q[0];
    assign motor_2_pwm = pwm_q[1];
    assign motor_3_pwm = pwm_q[2];
    assign motor_4_pwm = pwm_q[3];

endmodule

//--- logic/motor_mixer.sv
module motor_mixer import drone_pkg::*; (
    input  logic   sys_clk,
    input  logic   resetn,
    input  logic   corr_valid,
    input  logic   armed,
    input  stick_t throttle_cmd,
    input  rate_t  roll_corr,
    input  rate_t  pitch_corr,
    input  rate_t  yaw_corr,
    output stick_t motor_1_rate,
    output stick_t motor_2_rate,
    output stick_t motor_3_rate,
    output stick_t motor_4_rate
);

    // Limit a mixed sum to the motor range
    function automatic stick_t clamp_motor(input logic signed [10:0] v);
        if (v < 11'sd0) begin
            return '0;
        end else if (v > 11'(STICK_MAX)) begin
            return stick_t'(STICK_MAX);
        end
        return stick_t'(v);
    endfunction

    logic signed [10:0] thr;
    logic signed [10:0] p;
    logic signed [10:0] r;
    logic signed [10:0] y;
    logic signed [10:0] mix_1;
    logic signed [10:0] mix_2;
    logic signed [10:0] mix_3;
    logic signed [10:0] mix_4;

    // Quad-X layout, motors 1 and 3 spin one way, 2 and 4 the other
    always_comb begin
        thr   = $signed({3'b000, throttle_cmd});
        p     = 11'(pitch_corr);
        r     = 11'(roll_corr);
        y     = 11'(yaw_corr);
        // Front left
        mix_1 = thr + p + r - y;
        // Front right
        mix_2 = thr + p - r + y;
        // Rear right
        mix_3 = thr - p - r - y;
        // Rear left
        mix_4 = thr - p + r + y;
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            motor_1_rate <= '0;
            motor_2_rate <= '0;
            motor_3_rate <= '0;
            motor_4_rate <= '0;
        end else if (!armed) begin
            // Motors idle as soon as arming drops
            motor_1_rate <= '0;
            motor_2_rate <= '0;
            motor_3_rate <= '0;
            motor_4_rate <= '0;
        end else if (corr_valid) begin
            motor_1_rate <= clamp_motor(mix_1);
            motor_2_rate <= clamp_motor(mix_2);
            motor_3_rate <= clamp_motor(mix_3);
            motor_4_rate <= clamp_motor(mix_4);
        end
    end

endmodule

//--- logic/rate_controller.sv
module rate_controller import drone_pkg::*; (
    input  logic  sys_clk,
    input  logic  resetn,
    input  logic  targets_valid,
    input  rate_t roll_target,
    input  rate_t pitch_target,
    input  rate_t yaw_target,
    input  rate_t roll_rate,
    input  rate_t pitch_rate,
    input  rate_t yaw_rate,
    output rate_t roll_corr,
    output rate_t pitch_corr,
    output rate_t yaw_corr,
    output logic  corr_valid
);

    // Gyro sample from the imu_valid cycle, in step with the targets
    rate_t roll_rate_q;
    rate_t pitch_rate_q;
    rate_t yaw_rate_q;

    // Proportional term as the error scaled by a shift and then limited
    function automatic rate_t p_corr(input rate_t target, input rate_t rate);
        logic signed [10:0] err;
        logic signed [10:0] scaled;
        err    = 11'(target) - 11'(rate);
        scaled = err >>> RATE_SHIFT;
        if (scaled > 11'(CORR_LIMIT)) begin
            return rate_t'(CORR_LIMIT);
        end else if (scaled < -11'(CORR_LIMIT)) begin
            return rate_t'(-CORR_LIMIT);
        end
        return rate_t'(scaled);
    endfunction

    // Rates are only valid with imu_valid, one cycle ahead of targets_valid
    always_ff @(posedge sys_clk) begin
        roll_rate_q  <= roll_rate;
        pitch_rate_q <= pitch_rate;
        yaw_rate_q   <= yaw_rate;
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            corr_valid <= 1'b0;
        end else begin
            corr_valid <= targets_valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (targets_valid) begin
            roll_corr  <= p_corr(roll_target, roll_rate_q);
            pitch_corr <= p_corr(pitch_target, pitch_rate_q);
            yaw_corr   <= p_corr(yaw_target, yaw_rate_q);
        end
    end

endmodule

//--- logic/attitude_controller.sv
module attitude_controller import drone_pkg::*; (
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         imu_valid,
    input  flight_mode_t flight_mode,
    input  stick_t       roll_stick,
    input  stick_t       pitch_stick,
    input  stick_t       yaw_stick,
    input  rate_t        roll_angle,
    input  rate_t        pitch_angle,
    output rate_t        roll_target,
    output rate_t        pitch_target,
    output rate_t        yaw_target,
    output logic         targets_valid
);

    // Stick to signed offset around neutral
    function automatic logic signed [10:0] recenter(input stick_t s);
        return $signed({3'b000, s}) - 11'(STICK_CENTER);
    endfunction

    // Back into rate_t range
    function automatic rate_t sat_rate(input logic signed [10:0] v);
        if (v > 11'sd511) begin
            return 10'sd511;
        end else if (v < -11'sd512) begin
            return -10'sd512;
        end
        return rate_t'(v);
    endfunction

    logic use_angle;

    // Acro flies on stick rate alone
    assign use_angle = (flight_mode != mode_acro);

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            targets_valid <= 1'b0;
        end else begin
            targets_valid <= imu_valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (imu_valid) begin
            if (use_angle) begin
                roll_target  <= sat_rate(recenter(roll_stick) - 11'(roll_angle));
                pitch_target <= sat_rate(recenter(pitch_stick) - 11'(pitch_angle));
            end else begin
                roll_target  <= sat_rate(recenter(roll_stick));
                pitch_target <= sat_rate(recenter(pitch_stick));
            end
            // Yaw always rate controlled
            yaw_target <= sat_rate(recenter(yaw_stick));
        end
    end

endmodule

//--- logic/arming_controller.sv
module arming_controller import drone_pkg::*; (
    input  logic         sys_clk,
    input  logic         resetn,
    input  stick_t       mode_val,
    input  stick_t       throttle_val,
    output flight_mode_t flight_mode,
    output logic         armed,
    output stick_t       throttle_cmd
);

    flight_mode_t mode_next;
    logic         armed_next;

    // Three-position switch decode
    always_comb begin
        if (mode_val <= stick_t'(MODE_LOW_MAX)) begin
            mode_next = mode_off;
        end else if (mode_val <= stick_t'(MODE_MID_MAX)) begin
            mode_next = mode_stabilize;
        end else begin
            mode_next = mode_acro;
        end
    end

    // Arm only on the transition out of off with low throttle
    // A refused attempt stays refused since the transition is gone
    always_comb begin
        if (mode_next == mode_off) begin
            armed_next = 1'b0;
        end else if (armed) begin
            armed_next = 1'b1;
        end else begin
            armed_next = (flight_mode == mode_off) &&
                         (throttle_val < stick_t'(ARM_THROTTLE_MAX));
        end
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            flight_mode  <= mode_off;
            armed        <= 1'b0;
            throttle_cmd <= '0;
        end else begin
            flight_mode <= mode_next;
            armed       <= armed_next;
            // Throttle gated in step with armed
            throttle_cmd <= armed_next ? throttle_val : '0;
        end
    end

endmodule

//--- logic/rc_pulse_decoder.sv
module rc_pulse_decoder import drone_pkg::*; (
    input  logic   sys_clk,
    input  logic   resetn,
    input  logic   us_tick,
    input  logic   pulse_in,
    output stick_t value
);

    // Two-flop synchronizer plus one stage for edge detect
    logic pulse_meta;
    logic pulse_sync;
    logic pulse_prev;

    logic pulse_rise;
    logic pulse_fall;

    // High time of the current pulse
    us_count_t width_cnt;
    us_count_t width_clamped;

    assign pulse_rise = pulse_sync & ~pulse_prev;
    assign pulse_fall = ~pulse_sync & pulse_prev;

    // Limit width to the valid receiver range
    always_comb begin
        if (width_cnt < us_count_t'(PULSE_MIN_US)) begin
            width_clamped = us_count_t'(PULSE_MIN_US);
        end else if (width_cnt > us_count_t'(PULSE_MAX_US)) begin
            width_clamped = us_count_t'(PULSE_MAX_US);
        end else begin
            width_clamped = width_cnt;
        end
    end

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            pulse_meta <= 1'b0;
            pulse_sync <= 1'b0;
            pulse_prev <= 1'b0;
            width_cnt  <= '0;
            value      <= '0;
        end else begin
            pulse_meta <= pulse_in;
            pulse_sync <= pulse_meta;
            pulse_prev <= pulse_sync;

            // Restart on each rising edge, saturate on a stuck input
            if (pulse_rise) begin
                width_cnt <= '0;
            end else if (pulse_sync && us_tick && (width_cnt != '1)) begin
                width_cnt <= width_cnt + 1'b1;
            end

            // Glitches under half the minimum width are dropped
            if (pulse_fall && (width_cnt >= us_count_t'(PULSE_MIN_US / 2))) begin
                value <= stick_t'((width_clamped - us_count_t'(PULSE_MIN_US))
                                  / us_count_t'(US_PER_STEP));
            end
        end
    end

endmodule

//--- logic/timebase.sv
module timebase import drone_pkg::*; (
    input  logic sys_clk,
    input  logic resetn,
    output logic us_tick,
    output logic frame_start
);

    // Cycle divider state
    logic [$clog2(TICKS_PER_US)-1:0] tick_cnt;
    logic                            tick_wrap;

    // Microseconds into the current ESC frame
    us_count_t us_cnt;

    assign tick_wrap = (tick_cnt == TICKS_PER_US - 1);

    always_ff @(posedge sys_clk or negedge resetn) begin
        if (!resetn) begin
            tick_cnt    <= '0;
            us_cnt      <= '0;
            us_tick     <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            // One tick per TICKS_PER_US cycles
            if (tick_wrap) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            us_tick <= tick_wrap;

            // Frame boundary lands on the last tick of the window
            frame_start <= tick_wrap && (us_cnt == us_count_t'(FRAME_US - 1));
            if (tick_wrap) begin
                if (us_cnt == us_count_t'(FRAME_US - 1)) begin
                    us_cnt <= '0;
                end else begin
                    us_cnt <= us_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/drone_pkg.sv
package drone_pkg;

    // Clock and frame timing
    localparam int TICKS_PER_US = 38;
    localparam int FRAME_US     = 20000;

    // Receiver and ESC pulse bounds in microseconds
    localparam int PULSE_MIN_US = 1000;
    localparam int PULSE_MAX_US = 2000;
    localparam int US_PER_STEP  = 4;

    // Stick and motor scale
    localparam int STICK_MAX    = 250;
    localparam int STICK_CENTER = 125;

    // Mode switch thresholds
    localparam int MODE_LOW_MAX = 83;
    localparam int MODE_MID_MAX = 166;

    // Arming only allowed with throttle near the bottom
    localparam int ARM_THROTTLE_MAX = 10;

    // Proportional gain as a shift, plus correction clamp
    localparam int RATE_SHIFT = 1;
    localparam int CORR_LIMIT = 100;

    // Stick or motor value, 0 to STICK_MAX
    typedef logic [7:0] stick_t;

    // Signed angle, rate or correction in stick units
    typedef logic signed [9:0] rate_t;

    // Microsecond count
    typedef logic [15:0] us_count_t;

    typedef enum logic [1:0] {
        mode_off,
        mode_stabilize,
        mode_acro
    } flight_mode_t;

endpackage
